/* Bender.yml */
package:
  name: udp_tx

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/udp_hdr_pkg.sv
      - design/udp_tx_ctrl_pkg.sv
      - design/udp_header_builder.sv
      - design/frame_serializer.sv
      - design/phy_tx_sequencer.sv
      - design/udp_tx_top.sv
  - target: simulation
    include_dirs:
      - design
      - sim
    files:
      - sim/udp_tx_tb.sv

/* all.f */
+incdir+design
+incdir+sim
design/udp_hdr_pkg.sv
design/udp_tx_ctrl_pkg.sv
design/udp_header_builder.sv
design/frame_serializer.sv
design/phy_tx_sequencer.sv
design/udp_tx_top.sv
sim/udp_tx_tb.sv

/* design/frame_serializer.sv */
`include "udp_tx_cfg.svh"

module frame_serializer (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 frame_valid,
    input  udp_hdr_pkg::frame_t  frame,
    input  logic                 advance,
    output logic [3:0]           nibble,
    output logic                 last
);
    import udp_hdr_pkg::*;
    import udp_tx_ctrl_pkg::*;

    localparam int FRAME_BITS   = 8 * FRAME_BYTES;
    localparam int DATA_NIBBLES = 2 * FRAME_BYTES;
    localparam int FCS_NIBBLES  = 8;
    localparam int CNT_W        = $clog2(DATA_NIBBLES);

    localparam logic [CNT_W-1:0] LAST_DATA = CNT_W'(DATA_NIBBLES - 1);
    localparam logic [CNT_W-1:0] LAST_FCS  = CNT_W'(FCS_NIBBLES - 1);

    typedef logic [15:0][31:0] crc_table_t;

    // Remainder table for one nibble of the reflected CRC
    // Each entry is its index pushed through four bit steps
    function automatic crc_table_t build_crc_table();
        crc_table_t tbl;
        logic [31:0] r;
        for (int i = 0; i < 16; i++) begin
            r = 32'(i);
            for (int j = 0; j < 4; j++) begin
                r = r[0] ? ((r >> 1) ^ `UDP_CRC_POLY) : (r >> 1);
            end
            tbl[i] = r;
        end
        return tbl;
    endfunction

    localparam crc_table_t CRC_TABLE = build_crc_table();

    ser_phase_t       phase;
    logic [CNT_W-1:0] count;
    logic [FRAME_BITS-1:0] swapped;
    logic [FRAME_BITS-1:0] shift_reg;
    logic [31:0]      crc;
    logic [31:0]      crc_next;
    logic [3:0]       data_nibble;

    // Low nibble of each byte goes first, so swap the halves of every byte
    // Afterwards the wire order is simply top nibble first
    always_comb begin
        for (int b = 0; b < FRAME_BYTES; b++) begin
            swapped[8*b +: 8] = {frame[8*b +: 4], frame[8*b+4 +: 4]};
        end
    end

    assign data_nibble = shift_reg[FRAME_BITS-1 -: 4];

    // Fold the nibble being sent into the running CRC
    assign crc_next = (crc >> 4) ^ CRC_TABLE[crc[3:0] ^ data_nibble];

    // In the FCS phase the register already holds the complemented CRC
    // and its low nibble is the next one on the wire
    assign nibble = (phase == SER_DATA) ? data_nibble : crc[3:0];
    assign last   = (phase == SER_FCS) && (count == LAST_FCS);

    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= SER_DATA;
            count <= '0;
        end else if (frame_valid) begin
            phase <= SER_DATA;
            count <= '0;
        end else if (advance) begin
            if (phase == SER_DATA && count == LAST_DATA) begin
                phase <= SER_FCS;
                count <= '0;
            end else if (!last) begin
                count <= count + 1'b1;
            end
        end
    end

    // Frame storage and CRC are payload and are set up by frame_valid
    always_ff @(posedge clk) begin
        if (frame_valid) begin
            shift_reg <= swapped;
            crc       <= 32'hFFFF_FFFF;
        end else if (advance) begin
            shift_reg <= shift_reg << 4;
            if (phase == SER_DATA) begin
                // The final data nibble also finishes the CRC with its complement
                crc <= (count == LAST_DATA) ? ~crc_next : crc_next;
            end else begin
                crc <= crc >> 4;
            end
        end
    end

endmodule

/* design/phy_tx_sequencer.sv */
`include "udp_tx_cfg.svh"

module phy_tx_sequencer (
    input  logic        clk,
    input  logic        reset,
    input  logic        frame_valid,
    input  logic [3:0]  nibble,
    input  logic        last,
    output logic        advance,
    output logic        ready,
    output logic        tx_en,
    output logic [3:0]  tx_d
);
    import udp_tx_ctrl_pkg::*;

    localparam int DIV_W = $clog2(`UDP_PHY_DIVIDER);
    localparam int CNT_MAX = (`UDP_GAP_NIBBLES > `UDP_PREAMBLE_NIBBLES) ?
        `UDP_GAP_NIBBLES : `UDP_PREAMBLE_NIBBLES;
    localparam int CNT_W = $clog2(CNT_MAX + 1);

    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`UDP_PHY_DIVIDER - 1);
    localparam logic [CNT_W-1:0] SFD_CNT  = CNT_W'(`UDP_PREAMBLE_NIBBLES - 1);
    localparam logic [CNT_W-1:0] GAP_CNT  = CNT_W'(`UDP_GAP_NIBBLES);

    // Preamble nibbles are 0x5, the delimiter ends on 0xD
    localparam logic [3:0] PREAMBLE_NIB = 4'h5;
    localparam logic [3:0] SFD_NIB      = 4'hD;

    tx_state_t        state;
    logic [DIV_W-1:0] div_cnt;
    logic             strobe;
    logic [CNT_W-1:0] cnt;

    // Free running divider, one strobe per nibble time
    always_ff @(posedge clk) begin
        if (reset || div_cnt == DIV_LAST) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    assign strobe = (div_cnt == DIV_LAST);

    // The serializer steps on the same edge that tx_d takes its nibble
    assign advance = strobe && (state == TX_BODY);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= TX_IDLE;
            cnt   <= '0;
            ready <= 1'b1;
            tx_en <= 1'b0;
            tx_d  <= 4'h0;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (frame_valid) begin
                        ready <= 1'b0;
                        cnt   <= '0;
                        state <= TX_PREAMBLE;
                    end
                end
                TX_PREAMBLE: begin
                    if (strobe) begin
                        tx_en <= 1'b1;
                        if (cnt == SFD_CNT) begin
                            tx_d  <= SFD_NIB;
                            state <= TX_BODY;
                        end else begin
                            tx_d <= PREAMBLE_NIB;
                            cnt  <= cnt + 1'b1;
                        end
                    end
                end
                TX_BODY: begin
                    if (strobe) begin
                        tx_d <= nibble;
                        // Last FCS nibble still gets its full nibble time
                        if (last) begin
                            cnt   <= '0;
                            state <= TX_GAP;
                        end
                    end
                end
                TX_GAP: begin
                    // First strobe here ends the burst, then the gap is counted
                    if (strobe) begin
                        tx_en <= 1'b0;
                        tx_d  <= 4'h0;
                        if (cnt == GAP_CNT) begin
                            ready <= 1'b1;
                            state <= TX_IDLE;
                        end else begin
                            cnt <= cnt + 1'b1;
                        end
                    end
                end
                default: begin
                    state <= TX_IDLE;
                end
            endcase
        end
    end

endmodule

/* design/udp_hdr_pkg.sv */
`include "udp_tx_cfg.svh"

package udp_hdr_pkg;

    // Address and port types, all in network byte order
    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] port_t;

    // Ethernet II header, 14 bytes
    typedef struct packed {
        mac_addr_t   dest_mac;
        mac_addr_t   src_mac;
        logic [15:0] ether_type;
    } eth_header_t;

    // IPv4 header without options, 20 bytes, as laid out in RFC 791
    typedef struct packed {
        logic [3:0]  version;
        logic [3:0]  ihl;
        logic [7:0]  type_of_service;
        logic [15:0] total_length;
        logic [15:0] identification;
        logic [2:0]  flags;
        logic [12:0] fragment_offset;
        logic [7:0]  time_to_live;
        logic [7:0]  protocol;
        logic [15:0] header_checksum;
        ip_addr_t    src_ip;
        ip_addr_t    dest_ip;
    } ip_header_t;

    // UDP header, 8 bytes, as laid out in RFC 768
    typedef struct packed {
        port_t       src_port;
        port_t       dest_port;
        logic [15:0] length;
        logic [15:0] checksum;
    } udp_header_t;

    // Whole frame without preamble and FCS
    // The first byte on the wire sits in the most significant position
    typedef struct packed {
        eth_header_t                    eth;
        ip_header_t                     ip;
        udp_header_t                    udp;
        logic [8*`UDP_DATA_BYTES-1:0]   payload;
    } frame_t;

    localparam int FRAME_BYTES = $bits(frame_t) / 8;

endpackage

/* design/udp_header_builder.sv */
`include "udp_tx_cfg.svh"

module udp_header_builder (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          send,
    input  logic [8*`UDP_DATA_BYTES-1:0]  data,
    input  udp_hdr_pkg::mac_addr_t        src_mac,
    input  udp_hdr_pkg::mac_addr_t        dest_mac,
    input  udp_hdr_pkg::ip_addr_t         src_ip,
    input  udp_hdr_pkg::ip_addr_t         dest_ip,
    input  udp_hdr_pkg::port_t            src_port,
    input  udp_hdr_pkg::port_t            dest_port,
    input  logic                          ready,
    output logic                          frame_valid,
    output udp_hdr_pkg::frame_t           frame
);
    import udp_hdr_pkg::*;

    // Length fields follow from the fixed payload size
    localparam int UDP_BYTES = $bits(udp_header_t) / 8 + `UDP_DATA_BYTES;
    localparam int IP_BYTES  = $bits(ip_header_t) / 8 + UDP_BYTES;
    localparam int IP_WORDS  = $bits(ip_header_t) / 16;

    localparam logic [15:0] UDP_LENGTH   = 16'(UDP_BYTES);
    localparam logic [15:0] IP_TOTAL_LEN = 16'(IP_BYTES);

    logic        send_prev;
    logic        accept;
    eth_header_t eth_hdr;
    ip_header_t  ip_hdr;
    udp_header_t udp_hdr;
    frame_t      frame_next;

    // Sum of the header words and the two end-around carry folds
    logic [19:0] csum_acc;
    logic [16:0] csum_fold1;
    logic [15:0] csum_fold2;

    // A new frame starts only on a fresh rising edge while the sender is free
    // Checking frame_valid too covers the cycle before ready falls
    assign accept = send && !send_prev && ready && !frame_valid;

    always_comb begin
        eth_hdr.dest_mac   = dest_mac;
        eth_hdr.src_mac    = src_mac;
        eth_hdr.ether_type = `UDP_ETHER_TYPE_IPV4;

        // Version 4, five words of header, no fragmentation
        ip_hdr.version         = 4'd4;
        ip_hdr.ihl             = 4'd5;
        ip_hdr.type_of_service = `UDP_IP_TOS;
        ip_hdr.total_length    = IP_TOTAL_LEN;
        ip_hdr.identification  = 16'd0;
        ip_hdr.flags           = 3'd0;
        ip_hdr.fragment_offset = 13'd0;
        ip_hdr.time_to_live    = `UDP_IP_TTL;
        ip_hdr.protocol        = `UDP_IP_PROTOCOL;
        ip_hdr.header_checksum = 16'd0;
        ip_hdr.src_ip          = src_ip;
        ip_hdr.dest_ip         = dest_ip;

        // The checksum field is still zero while the words are summed
        csum_acc = 20'd0;
        for (int w = 0; w < IP_WORDS; w++) begin
            csum_acc = csum_acc + {4'd0, ip_hdr[16*w +: 16]};
        end
        // Carries out of bit 15 wrap back into the low end, twice at most
        csum_fold1 = {1'b0, csum_acc[15:0]} + {13'd0, csum_acc[19:16]};
        csum_fold2 = csum_fold1[15:0] + {15'd0, csum_fold1[16]};
        ip_hdr.header_checksum = ~csum_fold2;

        // UDP checksum zero means no checksum for IPv4
        udp_hdr.src_port  = src_port;
        udp_hdr.dest_port = dest_port;
        udp_hdr.length    = UDP_LENGTH;
        udp_hdr.checksum  = 16'd0;

        frame_next.eth     = eth_hdr;
        frame_next.ip      = ip_hdr;
        frame_next.udp     = udp_hdr;
        frame_next.payload = data;
    end

    // Edge detector starts at one so a send held high through reset is no edge
    always_ff @(posedge clk) begin
        if (reset) begin
            send_prev   <= 1'b1;
            frame_valid <= 1'b0;
        end else begin
            send_prev   <= send;
            frame_valid <= accept;
        end
    end

    // Frame contents land together with the frame_valid pulse
    always_ff @(posedge clk) begin
        if (accept) begin
            frame <= frame_next;
        end
    end

endmodule

/* design/udp_tx_cfg.svh */
`ifndef UDP_TX_CFG_SVH
`define UDP_TX_CFG_SVH

// Payload bytes carried by every datagram
// Eighteen bytes give a 64 byte frame without any padding
`define UDP_DATA_BYTES 18

// System clocks per nibble on the PHY side, never below 2
`define UDP_PHY_DIVIDER 4

// Interframe gap in nibble times, 12 byte times on the wire
`define UDP_GAP_NIBBLES 24

// Preamble nibbles including the start-of-frame delimiter
`define UDP_PREAMBLE_NIBBLES 16

// Protocol constants for the Ethernet and IPv4 headers
`define UDP_ETHER_TYPE_IPV4 16'h0800
`define UDP_IP_TOS 8'h0C
`define UDP_IP_TTL 8'hFF
`define UDP_IP_PROTOCOL 8'd17

// Reflected form of the CRC-32 polynomial 0x04C11DB7
`define UDP_CRC_POLY 32'hEDB88320

`endif

/* design/udp_tx_ctrl_pkg.sv */
package udp_tx_ctrl_pkg;

    // States of the PHY side sequencer
    // Idle waits for a frame, preamble covers the SFD too,
    // body carries frame and FCS nibbles, gap holds the line quiet
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_PREAMBLE,
        TX_BODY,
        TX_GAP
    } tx_state_t;

    // Phases of the serializer
    // Data walks the stored frame, FCS shifts out the finished CRC
    typedef enum logic {
        SER_DATA,
        SER_FCS
    } ser_phase_t;

endpackage

/* design/udp_tx_top.sv */
`include "udp_tx_cfg.svh"

module udp_tx_top (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          send,
    input  logic [8*`UDP_DATA_BYTES-1:0]  data,
    input  udp_hdr_pkg::mac_addr_t        src_mac,
    input  udp_hdr_pkg::mac_addr_t        dest_mac,
    input  udp_hdr_pkg::ip_addr_t         src_ip,
    input  udp_hdr_pkg::ip_addr_t         dest_ip,
    input  udp_hdr_pkg::port_t            src_port,
    input  udp_hdr_pkg::port_t            dest_port,
    output logic                          ready,
    output logic                          tx_en,
    output logic [3:0]                    tx_d
);
    import udp_hdr_pkg::*;

    logic       frame_valid;
    frame_t     frame;
    logic       advance;
    logic [3:0] nibble;
    logic       last;

    // Input side, edge detect and header assembly
    udp_header_builder u_builder (
        .clk         (clk),
        .reset       (reset),
        .send        (send),
        .data        (data),
        .src_mac     (src_mac),
        .dest_mac    (dest_mac),
        .src_ip      (src_ip),
        .dest_ip     (dest_ip),
        .src_port    (src_port),
        .dest_port   (dest_port),
        .ready       (ready),
        .frame_valid (frame_valid),
        .frame       (frame)
    );

    // Nibble stream and FCS
    frame_serializer u_serializer (
        .clk         (clk),
        .reset       (reset),
        .frame_valid (frame_valid),
        .frame       (frame),
        .advance     (advance),
        .nibble      (nibble),
        .last        (last)
    );

    // PHY timing, preamble and interframe gap
    phy_tx_sequencer u_sequencer (
        .clk         (clk),
        .reset       (reset),
        .frame_valid (frame_valid),
        .nibble      (nibble),
        .last        (last),
        .advance     (advance),
        .ready       (ready),
        .tx_en       (tx_en),
        .tx_d        (tx_d)
    );

endmodule

/* sim/udp_tx_model.svh */
`ifndef UDP_TX_MODEL_SVH
`define UDP_TX_MODEL_SVH

// Wire layout taken from the frame format, independent of the DUT types
localparam int PAYLOAD_BYTES  = `UDP_DATA_BYTES;
localparam int WIRE_BYTES     = 14 + 20 + 8 + PAYLOAD_BYTES;
localparam int STREAM_NIBBLES = `UDP_PREAMBLE_NIBBLES + 2 * (WIRE_BYTES + 4);

// Expected nibbles of one frame as seen on tx_d, nibble k at bits 4k+3..4k
function automatic logic [4*STREAM_NIBBLES-1:0] build_expected(
    input logic [8*`UDP_DATA_BYTES-1:0] payload,
    input mac_addr_t                    src_mac,
    input mac_addr_t                    dest_mac,
    input ip_addr_t                     src_ip,
    input ip_addr_t                     dest_ip,
    input port_t                        src_port,
    input port_t                        dest_port
);
    logic [7:0]                  b [WIRE_BYTES];
    logic [4*STREAM_NIBBLES-1:0] s;
    logic [15:0]                 word;
    logic [31:0]                 sum;
    logic [31:0]                 crc;
    int                          n;

    // Ethernet header, addresses sent most significant byte first
    for (int i = 0; i < 6; i++) begin
        b[i]     = dest_mac[47-8*i -: 8];
        b[6 + i] = src_mac[47-8*i -: 8];
    end
    word  = `UDP_ETHER_TYPE_IPV4;
    b[12] = word[15:8];
    b[13] = word[7:0];
    // IPv4 header with the checksum bytes still zero
    word  = 16'(20 + 8 + PAYLOAD_BYTES);
    b[14] = 8'h45;
    b[15] = `UDP_IP_TOS;
    b[16] = word[15:8];
    b[17] = word[7:0];
    for (int i = 18; i < 22; i++) begin
        b[i] = 8'h00;
    end
    b[22] = `UDP_IP_TTL;
    b[23] = `UDP_IP_PROTOCOL;
    b[24] = 8'h00;
    b[25] = 8'h00;
    for (int i = 0; i < 4; i++) begin
        b[26 + i] = src_ip[31-8*i -: 8];
        b[30 + i] = dest_ip[31-8*i -: 8];
    end
    // UDP header, length covers header and payload, checksum left at zero
    word  = 16'(8 + PAYLOAD_BYTES);
    b[34] = src_port[15:8];
    b[35] = src_port[7:0];
    b[36] = dest_port[15:8];
    b[37] = dest_port[7:0];
    b[38] = word[15:8];
    b[39] = word[7:0];
    b[40] = 8'h00;
    b[41] = 8'h00;
    for (int i = 0; i < PAYLOAD_BYTES; i++) begin
        b[42 + i] = payload[8*PAYLOAD_BYTES-1-8*i -: 8];
    end

    // Ones complement sum over the ten header words
    sum = 32'd0;
    for (int i = 0; i < 10; i++) begin
        sum = sum + {16'd0, b[14 + 2*i], b[15 + 2*i]};
    end
    sum   = {16'd0, sum[15:0]} + {16'd0, sum[31:16]};
    sum   = {16'd0, sum[15:0]} + {16'd0, sum[31:16]};
    word  = ~sum[15:0];
    b[24] = word[15:8];
    b[25] = word[7:0];

    // Bitwise reflected CRC-32, each byte fed least significant bit first
    crc = 32'hFFFF_FFFF;
    for (int i = 0; i < WIRE_BYTES; i++) begin
        for (int j = 0; j < 8; j++) begin
            if (crc[0] ^ b[i][j]) begin
                crc = (crc >> 1) ^ `UDP_CRC_POLY;
            end else begin
                crc = crc >> 1;
            end
        end
    end
    crc = ~crc;

    // Preamble, then bytes low nibble first, then FCS lowest byte first
    s = '0;
    n = 0;
    for (int i = 0; i < `UDP_PREAMBLE_NIBBLES - 1; i++) begin
        s[4*n +: 4] = 4'h5;
        n++;
    end
    s[4*n +: 4] = 4'hD;
    n++;
    for (int i = 0; i < WIRE_BYTES; i++) begin
        s[4*n +: 4] = b[i][3:0];
        s[4*n+4 +: 4] = b[i][7:4];
        n = n + 2;
    end
    for (int i = 0; i < 8; i++) begin
        s[4*n +: 4] = crc[4*i +: 4];
        n++;
    end
    return s;
endfunction

`endif

/* sim/udp_tx_tb.sv */
`include "udp_tx_cfg.svh"

module udp_tx_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import udp_hdr_pkg::*;

    `include "udp_tx_model.svh"

    // Each of the eight frames takes its preamble, body and gap plus a little slack
    localparam int NUM_FRAMES     = 8;
    localparam int DIV            = `UDP_PHY_DIVIDER;
    localparam int FRAME_CYCLES   = (STREAM_NIBBLES + `UDP_GAP_NIBBLES + 4) * DIV;
    localparam int TIMEOUT_CYCLES = NUM_FRAMES * FRAME_CYCLES + 2500;

    logic                         clk = 1'b0;
    logic                         reset;
    logic                         send;
    logic [8*`UDP_DATA_BYTES-1:0] data;
    mac_addr_t                    src_mac;
    mac_addr_t                    dest_mac;
    ip_addr_t                     src_ip;
    ip_addr_t                     dest_ip;
    port_t                        src_port;
    port_t                        dest_port;
    logic                         ready;
    logic                         tx_en;
    logic [3:0]                   tx_d;

    // Expected streams and names are queued when a send is issued
    logic [4*STREAM_NIBBLES-1:0]  exp_q [$];
    logic [4*STREAM_NIBBLES-1:0]  got_q [$];
    string                        name_q [$];
    int value_errors   = 0;
    int other_errors   = 0;
    int cycle_count    = 0;
    int frames_sent    = 0;
    int frames_checked = 0;

    // Capture state
    logic                         in_burst;
    int                           burst_cycles;
    int                           low_cycles;
    int                           bursts_seen = 0;
    logic [3:0]                   hold_val;
    logic [4*STREAM_NIBBLES-1:0]  cap_frame;

    // Compare state
    logic [4*STREAM_NIBBLES-1:0]  got_frame;
    logic [4*STREAM_NIBBLES-1:0]  exp_frame;
    string                        exp_name;

    udp_tx_top DUT (
        .clk       (clk),
        .reset     (reset),
        .send      (send),
        .data      (data),
        .src_mac   (src_mac),
        .dest_mac  (dest_mac),
        .src_ip    (src_ip),
        .dest_ip   (dest_ip),
        .src_port  (src_port),
        .dest_port (dest_port),
        .ready     (ready),
        .tx_en     (tx_en),
        .tx_d      (tx_d)
    );

    always #20 clk = ~clk;

    function automatic string current_test();
        return (name_q.size() > 0) ? name_q[0] : "no_request";
    endfunction

    task automatic report_counts();
        $display("Errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
    endtask

    // Run limit
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            other_errors++;
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            report_counts();
            $display("Finished with errors");
            $finish;
        end
    end

    // The wire is sampled on the falling edge between DUT updates
    always @(negedge clk) begin
        if (reset) begin
            in_burst   = 1'b0;
            low_cycles = 0;
        end else if (tx_en) begin
            if (!in_burst) begin
                // Quiet time before this burst is measured from the end of the last one
                if (bursts_seen > 0) begin
                    assert (low_cycles >= `UDP_GAP_NIBBLES * DIV) else begin
                        value_errors++;
                        $display("ERROR %s: gap expected at least %0d cycles, actual %0d",
                                 current_test(), `UDP_GAP_NIBBLES * DIV, low_cycles);
                    end
                end
                in_burst     = 1'b1;
                burst_cycles = 0;
                cap_frame    = '0;
            end
            assert (!ready) else begin
                other_errors++;
                $display("ready was high while tx_en was still sending a frame");
            end
            // Nibbles line up with the burst start and change once every DIV cycles
            if (burst_cycles % DIV == 0) begin
                hold_val = tx_d;
                if (burst_cycles / DIV < STREAM_NIBBLES) begin
                    cap_frame[4*(burst_cycles/DIV) +: 4] = tx_d;
                end
            end else begin
                assert (tx_d === hold_val) else begin
                    value_errors++;
                    $display("ERROR %s: nibble %0d hold expected %h, actual %h",
                             current_test(), burst_cycles / DIV, hold_val, tx_d);
                end
            end
            burst_cycles++;
        end else begin
            if (in_burst) begin
                in_burst = 1'b0;
                bursts_seen++;
                assert (burst_cycles == STREAM_NIBBLES * DIV) else begin
                    value_errors++;
                    $display("ERROR %s: burst length expected %0d cycles, actual %0d",
                             current_test(), STREAM_NIBBLES * DIV, burst_cycles);
                end
                got_q.push_back(cap_frame);
                low_cycles = 0;
            end
            low_cycles++;
        end
    end

    // Each captured frame is checked against the oldest outstanding request
    always @(posedge clk) begin
        if (got_q.size() > 0) begin
            got_frame = got_q.pop_front();
            assert (exp_q.size() > 0) else begin
                other_errors++;
                $display("a frame appeared on the wire without any send request for it");
            end
            if (exp_q.size() > 0) begin
                exp_frame = exp_q.pop_front();
                exp_name  = name_q.pop_front();
                for (int k = 0; k < STREAM_NIBBLES; k++) begin
                    assert (got_frame[4*k +: 4] === exp_frame[4*k +: 4]) else begin
                        value_errors++;
                        $display("ERROR %s: nibble %0d expected %h, actual %h",
                                 exp_name, k, exp_frame[4*k +: 4], got_frame[4*k +: 4]);
                    end
                end
                frames_checked++;
            end
        end
    end

    task automatic step_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic randomize_inputs();
        for (int i = 0; i < `UDP_DATA_BYTES; i++) begin
            data[8*i +: 8] = 8'($urandom);
        end
        src_mac   = {16'($urandom), $urandom};
        dest_mac  = {16'($urandom), $urandom};
        src_ip    = $urandom;
        dest_ip   = $urandom;
        src_port  = 16'($urandom);
        dest_port = 16'($urandom);
    endtask

    // Called with ready high and send low, so this edge is always accepted
    task automatic request_frame(input string name);
        send = 1'b1;
        exp_q.push_back(build_expected(data, src_mac, dest_mac, src_ip, dest_ip,
                                       src_port, dest_port));
        name_q.push_back(name);
        frames_sent++;
    endtask

    task automatic hold_until_busy();
        while (ready) begin
            step_cycles(1);
        end
    endtask

    task automatic hold_until_ready();
        while (!ready) begin
            step_cycles(1);
        end
    endtask

    initial begin
        void'($urandom(32'hd9ca1517));
        reset     = 1'b1;
        send      = 1'b0;
        data      = '0;
        src_mac   = '0;
        dest_mac  = '0;
        src_ip    = '0;
        dest_ip   = '0;
        src_port  = '0;
        dest_port = '0;
        repeat (8) @(posedge clk);
        #2;
        reset = 1'b0;

        step_cycles(1);
        assert (ready === 1'b1 && tx_en === 1'b0) else begin
            other_errors++;
            $display("after reset ready was %b and tx_en was %b, not ready high and tx_en low",
                     ready, tx_en);
        end

        randomize_inputs();
        request_frame("single_frame");
        hold_until_busy();
        send = 1'b0;
        hold_until_ready();

        // Each send goes out on the first drive slot after ready rises
        for (int i = 0; i < 3; i++) begin
            randomize_inputs();
            request_frame("back_to_back");
            hold_until_busy();
            send = 1'b0;
            hold_until_ready();
        end

        // A fresh edge while busy must be dropped
        randomize_inputs();
        request_frame("edge_while_busy");
        hold_until_busy();
        send = 1'b0;
        step_cycles(3);
        send = 1'b1;
        step_cycles(2);
        send = 1'b0;
        hold_until_ready();
        step_cycles(5);

        // Send stays high past the return of ready
        randomize_inputs();
        request_frame("send_held_high");
        hold_until_busy();
        hold_until_ready();
        step_cycles(4 * DIV);
        send = 1'b0;
        step_cycles(2);

        for (int i = 0; i < 2; i++) begin
            randomize_inputs();
            request_frame("random_frame");
            hold_until_busy();
            send = 1'b0;
            hold_until_ready();
            step_cycles(5);
        end

        while (frames_checked < frames_sent) begin
            step_cycles(1);
        end
        step_cycles(4 * DIV);
        assert (ready === 1'b1 && tx_en === 1'b0 && got_q.size() == 0) else begin
            other_errors++;
            $display("the sender started another frame after the last request");
        end

        report_counts();
        if (value_errors + other_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
